/* pe_pkg.sv */
package pe_pkg;

    // scratchpad geometry
    localparam int BYTE_W        = 8;
    localparam int IFMAP_DEPTH   = 5;
    localparam int FILTER_DEPTH  = 5;
    localparam int IFMAP_ADDR_W  = 3;
    localparam int FILTER_ADDR_W = 3;

    // one partial sum per filter position across the ifmap row
    localparam int NUM_OUTPUTS = IFMAP_DEPTH - FILTER_DEPTH + 1;

    // packet fields
    localparam int NODE_ADDR_W = 4;
    localparam int HOP_W       = 2;
    localparam int PAYLOAD_W   = 40;

    // 5 products of 255*255 need 19 bits, one spare
    localparam int PSUM_W = 20;

    localparam int PACKET_W = 57;

    // bit 56 of a packet, selects the target scratchpad
    typedef enum logic {
        PKT_FILTER = 1'b0,
        PKT_IFMAP  = 1'b1
    } pkt_kind_e;

    // routing header, MSB first
    typedef struct packed {
        logic [NODE_ADDR_W-1:0] source;
        logic [NODE_ADDR_W-1:0] dest;
        logic [1:0]             reserved;
        logic                   x_dir;
        logic                   y_dir;
        logic [HOP_W-1:0]       x_hop;
        logic [HOP_W-1:0]       y_hop;
    } route_hdr_t;

    // payload byte i sits at bits 8i+7..8i
    typedef struct packed {
        pkt_kind_e              kind;
        route_hdr_t             hdr;
        logic [PAYLOAD_W-1:0]   payload;
    } packet_t;

    // flags that travel with one tap through the MAC
    typedef struct packed {
        logic valid;
        logic first;
        logic last;
    } mac_op_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

    typedef enum logic {
        LOAD_IDLE,
        LOAD_WRITE
    } load_state_e;

endpackage

/* pe_spad.sv */
`timescale 1ns/10ps

module pe_spad #(
    parameter int DEPTH  = 5,
    parameter int ADDR_W = 3
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      we,
    input  logic [ADDR_W-1:0]         waddr,
    input  logic [pe_pkg::BYTE_W-1:0] wdata,
    input  logic [ADDR_W-1:0]         raddr,
    output logic [pe_pkg::BYTE_W-1:0] rdata
);
    import pe_pkg::*;

    logic [BYTE_W-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read data lands one cycle after the address
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* pe_depacketizer.sv */
`timescale 1ns/10ps

module pe_depacketizer (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             in_valid,
    input  pe_pkg::packet_t                  in_packet,
    input  logic                             busy,
    output logic                             ifmap_we,
    output logic [pe_pkg::IFMAP_ADDR_W-1:0]  ifmap_waddr,
    output logic [pe_pkg::BYTE_W-1:0]        ifmap_wdata,
    output logic                             filter_we,
    output logic [pe_pkg::FILTER_ADDR_W-1:0] filter_waddr,
    output logic [pe_pkg::BYTE_W-1:0]        filter_wdata,
    output logic                             start,
    output pe_pkg::route_hdr_t               hdr_held
);
    import pe_pkg::*;

    load_state_e             state_q;
    pkt_kind_e               kind_q;
    logic [PAYLOAD_W-1:0]    payload_q;
    logic [IFMAP_ADDR_W-1:0] byte_cnt_q;
    logic                    ifmap_loaded_q;
    logic                    filter_loaded_q;
    logic                    accept;
    logic                    last_byte;
    logic [BYTE_W-1:0]       cur_byte;

    assign start = ifmap_loaded_q && filter_loaded_q;

    // the start cycle is blocked too, the sequencer reads from the next cycle on
    assign accept = in_valid && (state_q == LOAD_IDLE) && !busy && !start;

    assign cur_byte = payload_q[byte_cnt_q*BYTE_W +: BYTE_W];

    always_comb begin
        if (kind_q == PKT_IFMAP) begin
            last_byte = (byte_cnt_q == IFMAP_ADDR_W'(IFMAP_DEPTH - 1));
        end else begin
            last_byte = (byte_cnt_q == IFMAP_ADDR_W'(FILTER_DEPTH - 1));
        end
    end

    assign ifmap_we     = (state_q == LOAD_WRITE) && (kind_q == PKT_IFMAP);
    assign ifmap_waddr  = byte_cnt_q;
    assign ifmap_wdata  = cur_byte;
    assign filter_we    = (state_q == LOAD_WRITE) && (kind_q == PKT_FILTER);
    assign filter_waddr = byte_cnt_q[FILTER_ADDR_W-1:0];
    assign filter_wdata = cur_byte;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q         <= LOAD_IDLE;
            byte_cnt_q      <= '0;
            ifmap_loaded_q  <= 1'b0;
            filter_loaded_q <= 1'b0;
        end else begin
            case (state_q)
                LOAD_IDLE: begin
                    if (accept) begin
                        state_q    <= LOAD_WRITE;
                        byte_cnt_q <= '0;
                    end
                end
                LOAD_WRITE: begin
                    if (last_byte) begin
                        state_q <= LOAD_IDLE;
                    end else begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                    end
                end
                default: state_q <= LOAD_IDLE;
            endcase

            // both flags drop together once the run is launched
            if (start) begin
                ifmap_loaded_q  <= 1'b0;
                filter_loaded_q <= 1'b0;
            end else if ((state_q == LOAD_WRITE) && last_byte) begin
                if (kind_q == PKT_IFMAP) begin
                    ifmap_loaded_q <= 1'b1;
                end else begin
                    filter_loaded_q <= 1'b1;
                end
            end
        end
    end

    // packet capture, the latest accepted header wins
    always_ff @(posedge clk) begin
        if (accept) begin
            kind_q    <= in_packet.kind;
            payload_q <= in_packet.payload;
            hdr_held  <= in_packet.hdr;
        end
    end

endmodule

/* pe_tap_sequencer.sv */
`timescale 1ns/10ps

module pe_tap_sequencer (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             start,
    output logic [pe_pkg::IFMAP_ADDR_W-1:0]  ifmap_raddr,
    output logic [pe_pkg::FILTER_ADDR_W-1:0] filter_raddr,
    output pe_pkg::mac_op_t                  op,
    output logic                             busy
);
    import pe_pkg::*;

    seq_state_e               state_q;
    logic [FILTER_ADDR_W-1:0] tap_q;
    logic [IFMAP_ADDR_W-1:0]  out_q;
    logic [1:0]               drain_q;
    logic                     last_tap;
    logic                     last_out;

    assign last_tap = (tap_q == FILTER_ADDR_W'(FILTER_DEPTH - 1));
    assign last_out = (out_q == IFMAP_ADDR_W'(NUM_OUTPUTS - 1));

    // output n, tap k reads ifmap[n+k] and filter[k]
    assign ifmap_raddr  = out_q + IFMAP_ADDR_W'(tap_q);
    assign filter_raddr = tap_q;

    always_comb begin
        op.valid = (state_q == SEQ_RUN);
        op.first = (state_q == SEQ_RUN) && (tap_q == '0);
        op.last  = (state_q == SEQ_RUN) && last_tap;
    end

    // drain covers the spad read and the MAC register after the final tap
    assign busy = (state_q == SEQ_RUN) || (drain_q != 2'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= SEQ_IDLE;
            tap_q   <= '0;
            out_q   <= '0;
            drain_q <= 2'd0;
        end else begin
            if (drain_q != 2'd0) begin
                drain_q <= drain_q - 2'd1;
            end

            case (state_q)
                SEQ_IDLE: begin
                    if (start) begin
                        state_q <= SEQ_RUN;
                        tap_q   <= '0;
                        out_q   <= '0;
                    end
                end
                SEQ_RUN: begin
                    if (last_tap) begin
                        tap_q <= '0;
                        if (last_out) begin
                            state_q <= SEQ_IDLE;
                            drain_q <= 2'd2;
                        end else begin
                            out_q <= out_q + 1'b1;
                        end
                    end else begin
                        tap_q <= tap_q + 1'b1;
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

endmodule

/* pe_mac.sv */
`timescale 1ns/10ps

module pe_mac (
    input  logic                      clk,
    input  logic                      arst_n,
    input  pe_pkg::mac_op_t           op,
    input  logic [pe_pkg::BYTE_W-1:0] ifmap_byte,
    input  logic [pe_pkg::BYTE_W-1:0] filter_byte,
    output logic                      psum_valid,
    output logic [pe_pkg::PSUM_W-1:0] psum
);
    import pe_pkg::*;

    mac_op_t             op_q;
    logic [2*BYTE_W-1:0] product;
    logic [PSUM_W-1:0]   acc_next;

    // op_q lines up with the bytes read for that tap
    assign product = ifmap_byte * filter_byte;

    // first tap restarts the sum, so outputs can follow back to back
    assign acc_next = op_q.first ? PSUM_W'(product) : psum + PSUM_W'(product);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_q       <= '0;
            psum_valid <= 1'b0;
        end else begin
            op_q       <= op;
            psum_valid <= op_q.valid && op_q.last;
        end
    end

    // psum doubles as the accumulator
    always_ff @(posedge clk) begin
        if (op_q.valid) begin
            psum <= acc_next;
        end
    end

endmodule

/* pe_packetizer.sv */
`timescale 1ns/10ps

module pe_packetizer (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      psum_valid,
    input  logic [pe_pkg::PSUM_W-1:0] psum,
    input  pe_pkg::route_hdr_t        hdr_held,
    output logic                      out_valid,
    output pe_pkg::packet_t           out_packet
);
    import pe_pkg::*;

    packet_t pkt_next;

    // outgoing psums are tagged as filter kind, reserved bits cleared
    always_comb begin
        pkt_next              = '0;
        pkt_next.kind         = PKT_FILTER;
        pkt_next.hdr          = hdr_held;
        pkt_next.hdr.reserved = 2'b00;
        pkt_next.payload      = PAYLOAD_W'(psum);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= psum_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (psum_valid) begin
            out_packet <= pkt_next;
        end
    end

endmodule

/* pe_top.sv */
`timescale 1ns/10ps

module pe_top (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  pe_pkg::packet_t in_packet,
    output logic            out_valid,
    output pe_pkg::packet_t out_packet,
    output logic            busy
);
    import pe_pkg::*;

    // input side
    logic                     ifmap_we;
    logic [IFMAP_ADDR_W-1:0]  ifmap_waddr;
    logic [BYTE_W-1:0]        ifmap_wdata;
    logic                     filter_we;
    logic [FILTER_ADDR_W-1:0] filter_waddr;
    logic [BYTE_W-1:0]        filter_wdata;
    logic                     start;
    route_hdr_t               hdr_held;

    // processing
    logic [IFMAP_ADDR_W-1:0]  ifmap_raddr;
    logic [FILTER_ADDR_W-1:0] filter_raddr;
    logic [BYTE_W-1:0]        ifmap_rdata;
    logic [BYTE_W-1:0]        filter_rdata;
    mac_op_t                  op;
    logic                     psum_valid;
    logic [PSUM_W-1:0]        psum;

    pe_depacketizer u_depacketizer (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_packet    (in_packet),
        .busy         (busy),
        .ifmap_we     (ifmap_we),
        .ifmap_waddr  (ifmap_waddr),
        .ifmap_wdata  (ifmap_wdata),
        .filter_we    (filter_we),
        .filter_waddr (filter_waddr),
        .filter_wdata (filter_wdata),
        .start        (start),
        .hdr_held     (hdr_held)
    );

    pe_spad #(.DEPTH(IFMAP_DEPTH), .ADDR_W(IFMAP_ADDR_W)) u_ifmap_spad (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (ifmap_we),
        .waddr  (ifmap_waddr),
        .wdata  (ifmap_wdata),
        .raddr  (ifmap_raddr),
        .rdata  (ifmap_rdata)
    );

    pe_spad #(.DEPTH(FILTER_DEPTH), .ADDR_W(FILTER_ADDR_W)) u_filter_spad (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (filter_we),
        .waddr  (filter_waddr),
        .wdata  (filter_wdata),
        .raddr  (filter_raddr),
        .rdata  (filter_rdata)
    );

    pe_tap_sequencer u_tap_sequencer (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .ifmap_raddr  (ifmap_raddr),
        .filter_raddr (filter_raddr),
        .op           (op),
        .busy         (busy)
    );

    pe_mac u_mac (
        .clk         (clk),
        .arst_n      (arst_n),
        .op          (op),
        .ifmap_byte  (ifmap_rdata),
        .filter_byte (filter_rdata),
        .psum_valid  (psum_valid),
        .psum        (psum)
    );

    pe_packetizer u_packetizer (
        .clk        (clk),
        .arst_n     (arst_n),
        .psum_valid (psum_valid),
        .psum       (psum),
        .hdr_held   (hdr_held),
        .out_valid  (out_valid),
        .out_packet (out_packet)
    );

endmodule

/* tb_pe.sv */
`timescale 1ns/10ps

module tb_pe;
    import pe_pkg::*;

    localparam int WAIT_LIMIT = 200;
    // one scratchpad write per byte plus margin for the loaded flag
    localparam int LOAD_GAP   = IFMAP_DEPTH + FILTER_DEPTH;
    localparam int NUM_RANDOM = 20;

    logic       clk;
    logic       arst_n;
    logic       in_valid;
    packet_t    in_packet;
    logic       out_valid;
    packet_t    out_packet;
    logic       busy;

    // expected output packets in arrival order
    packet_t    exp_q[$];
    packet_t    exp_head;
    int         exp_count;
    logic       quiet_phase;
    string      test_name;

    logic [BYTE_W-1:0] ifm_b [IFMAP_DEPTH];
    logic [BYTE_W-1:0] flt_b [FILTER_DEPTH];
    route_hdr_t        hdr_i;
    route_hdr_t        hdr_f;

    pe_top uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_packet  (in_packet),
        .out_valid  (out_valid),
        .out_packet (out_packet),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic void refresh_head();
        exp_count = exp_q.size();
        if (exp_count > 0) begin
            exp_head = exp_q[0];
        end else begin
            exp_head = '0;
        end
    endfunction

    // partial sum n = sum over j of ifmap[n+j] * filter[j]
    function automatic logic [PSUM_W-1:0] ref_psum(input int n);
        int sum;
        sum = 0;
        for (int j = 0; j < FILTER_DEPTH; j++) begin
            sum += int'(ifm_b[n+j]) * int'(flt_b[j]);
        end
        return PSUM_W'(sum);
    endfunction

    function automatic packet_t expected_packet(input route_hdr_t hdr, input int n);
        packet_t p;
        p              = '0;
        p.kind         = PKT_FILTER;
        p.hdr          = hdr;
        p.hdr.reserved = 2'b00;
        p.payload      = PAYLOAD_W'(ref_psum(n));
        return p;
    endfunction

    function automatic packet_t make_packet(input pkt_kind_e kind, input route_hdr_t hdr);
        packet_t p;
        p      = '0;
        p.kind = kind;
        p.hdr  = hdr;
        if (kind == PKT_IFMAP) begin
            for (int i = 0; i < IFMAP_DEPTH; i++) begin
                p.payload[i*BYTE_W +: BYTE_W] = ifm_b[i];
            end
        end else begin
            for (int i = 0; i < FILTER_DEPTH; i++) begin
                p.payload[i*BYTE_W +: BYTE_W] = flt_b[i];
            end
        end
        return p;
    endfunction

    function automatic void push_expected(input route_hdr_t hdr);
        for (int n = 0; n < NUM_OUTPUTS; n++) begin
            exp_q.push_back(expected_packet(hdr, n));
        end
        refresh_head();
    endfunction

    // saturate gives all-255 bytes as the worst case for the sum width
    task automatic randomize_data(input bit saturate);
        for (int i = 0; i < IFMAP_DEPTH; i++) begin
            ifm_b[i] = saturate ? 8'hff : 8'($urandom);
        end
        for (int i = 0; i < FILTER_DEPTH; i++) begin
            flt_b[i] = saturate ? 8'hff : 8'($urandom);
        end
        hdr_i = 16'($urandom);
        hdr_f = 16'($urandom);
    endtask

    task automatic send_packet(input packet_t p);
        @(posedge clk);
        in_valid  <= 1'b1;
        in_packet <= p;
        @(posedge clk);
        in_valid  <= 1'b0;
    endtask

    task automatic load_packet(input packet_t p);
        send_packet(p);
        repeat (LOAD_GAP) @(posedge clk);
    endtask

    task automatic wait_busy(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (busy !== level && cycles < WAIT_LIMIT);
        if (busy !== level) begin
            fail_stop($sformatf("%s: busy never went to %0b", test_name, level));
        end
    endtask

    // counts output strobes until busy has dropped
    task automatic count_outputs(output int count);
        int cycles;
        count  = 0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (out_valid === 1'b1) begin
                count++;
            end
        end while (busy !== 1'b0 && cycles < WAIT_LIMIT);
        if (busy !== 1'b0) begin
            fail_stop($sformatf("%s: busy never went to 0", test_name));
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (exp_q.size() != 0 && cycles < WAIT_LIMIT);
        if (exp_q.size() != 0) begin
            fail_stop($sformatf("%s: %0d output packets never arrived",
                                test_name, exp_q.size()));
        end
    endtask

    task automatic check_count(input int actual);
        assert (actual == NUM_OUTPUTS)
        else fail_stop($sformatf("CHECK FAILED %s output count expected %0d actual %0d",
                                 test_name, NUM_OUTPUTS, actual));
    endtask

    task automatic run_pair(input string name, input bit ifmap_first);
        int n_out;
        test_name = name;
        if (ifmap_first) begin
            load_packet(make_packet(PKT_IFMAP, hdr_i));
            push_expected(hdr_f);
            send_packet(make_packet(PKT_FILTER, hdr_f));
        end else begin
            load_packet(make_packet(PKT_FILTER, hdr_f));
            push_expected(hdr_i);
            send_packet(make_packet(PKT_IFMAP, hdr_i));
        end
        wait_busy(1'b1);
        count_outputs(n_out);
        check_count(n_out);
        wait_drained();
    endtask

    // retire the head once its output packet has been checked
    always @(posedge clk) begin
        if (arst_n && out_valid && exp_q.size() > 0) begin
            exp_q.delete(0);
            refresh_head();
        end
    end

    a_idle_quiet: assert property (@(posedge clk)
        (!arst_n || quiet_phase) |-> (!busy && !out_valid))
    else fail_stop($sformatf("%s: busy or an output appeared while the PE should be idle",
                             test_name));

    a_output_expected: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> exp_count > 0)
    else fail_stop($sformatf("%s: an output packet appeared that was not expected", test_name));

    a_packet_match: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && exp_count > 0) |-> out_packet == exp_head)
    else fail_stop($sformatf("CHECK FAILED %s expected %h actual %h",
                             test_name, $sampled(exp_head), $sampled(out_packet)));

    initial begin
        int      n_out;
        packet_t extra;
        in_valid    = 1'b0;
        in_packet   = '0;
        arst_n      = 1'b0;
        quiet_phase = 1'b1;
        test_name   = "reset";
        refresh_head();
        void'($urandom(62668));
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        // a single ifmap must not start anything
        test_name = "lone_ifmap";
        randomize_data(1'b0);
        load_packet(make_packet(PKT_IFMAP, hdr_i));
        repeat (WAIT_LIMIT / 4) @(posedge clk);
        quiet_phase = 1'b0;

        randomize_data(1'b0);
        run_pair("ifmap_then_filter", 1'b1);
        randomize_data(1'b0);
        run_pair("filter_then_ifmap", 1'b0);

        // first ifmap gets overwritten by the second
        test_name = "ifmap_twice";
        randomize_data(1'b0);
        load_packet(make_packet(PKT_IFMAP, hdr_i));
        randomize_data(1'b0);
        run_pair("ifmap_twice", 1'b1);

        // extra ifmap during the run is dropped
        test_name = "busy_drop";
        randomize_data(1'b0);
        load_packet(make_packet(PKT_IFMAP, hdr_i));
        push_expected(hdr_f);
        send_packet(make_packet(PKT_FILTER, hdr_f));
        wait_busy(1'b1);
        extra         = make_packet(PKT_IFMAP, hdr_i);
        extra.payload = ~extra.payload;
        send_packet(extra);
        count_outputs(n_out);
        check_count(n_out);
        wait_drained();

        // with filter first a kept extra ifmap would start a wrong run early
        randomize_data(1'b0);
        run_pair("after_drop", 1'b0);

        for (int r = 0; r < NUM_RANDOM; r++) begin
            randomize_data(r == 0 || r == NUM_RANDOM / 2);
            run_pair($sformatf("random_%0d", r), 1'($urandom_range(0, 1)));
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* tb.f */
pe_pkg.sv
pe_spad.sv
pe_depacketizer.sv
pe_tap_sequencer.sv
pe_mac.sv
pe_packetizer.sv
pe_top.sv
tb_pe.sv

/* Bender.yml */
package:
  name: pe_conv

sources:
  - pe_pkg.sv
  - pe_spad.sv
  - pe_depacketizer.sv
  - pe_tap_sequencer.sv
  - pe_mac.sv
  - pe_packetizer.sv
  - pe_top.sv
  - target: simulation
    files:
      - tb_pe.sv
